//--- hw/hrfp_pkg.sv
/*
 hrfp16 format constants: sign, base-16 exponent with bias 128, 27-bit fraction
 whose top hex digit is nonzero. An exponent field of 0 encodes zero.
 The RTL works only with these values.
*/

`default_nettype none

package hrfp_pkg;

   // word layout, msb first: sign, exponent, mantissa
   localparam int MANT_W = 27;
   localparam int EXP_W  = 8;
   localparam int WORD_W = 1 + EXP_W + MANT_W;

   // full width of the mantissa product
   localparam int PROD_W = 2 * MANT_W;

   // signed exponent sum, wide enough for ea + eb - bias and one decrement
   localparam int SUM_W = EXP_W + 2;

   localparam int EXP_BIAS = 128;

   // largest exponent field; results above it saturate
   localparam int EXP_MAX = (1 << EXP_W) - 1;

   // register stages in the mantissa multiplier
   localparam int MULT_LATENCY = 4;

   // accepted input to registered result at the top level,
   // the multiplier plus the normalizer output register
   localparam int MUL_LATENCY = MULT_LATENCY + 1;

endpackage

`default_nettype wire

//--- hw/hrfp_side_if.sv
/*
 Side data that travels next to the mantissa product.
 The producer delays it so it lines up with the multiplier output.
*/

`timescale 1ns/1ps
`default_nettype none

interface hrfp_side_if import hrfp_pkg::*; ();

   logic                    sign;
   // ea + eb - bias, before the normalization adjust
   logic signed [SUM_W-1:0] exp_sum;
   // one of the operands was zero
   logic                    zero;
   logic                    valid;

   modport producer (output sign, output exp_sum, output zero, output valid);

   modport consumer (input sign, input exp_sum, input zero, input valid);

endinterface

`default_nettype wire

//--- hw/mult_27x27.sv
/*
 Exact 27x27 unsigned product, four register stages, no reset.
 Input rule: if opa[26] is set, opa[2:0] must be zero, else the pre-add
 of opa[26:3] and opa[2] overflows 24 bits and the product is wrong.
*/

`timescale 1ns/1ps
`default_nettype none

module mult_27x27
   import hrfp_pkg::*;
(
   input  wire              clk,
   input  wire [MANT_W-1:0] opa,
   input  wire [MANT_W-1:0] opb,
   output logic [PROD_W-1:0] res
);

   // opa split: 24 high bits times opb, 3 low bits handled by the correction
   localparam int HI_W   = 24;
   localparam int LO_B_W = 17;
   localparam int HI_B_W = MANT_W - LO_B_W;

   // opa = 8 * (opa[26:3] + opa[2]) +/- fix, with fix a small multiple of opb:
   // al = 0..3 adds al * opb, al = 4..7 subtracts (8 - al) * opb
   logic [MANT_W+1:0] fix;
   logic              borrow;
   logic [MANT_W-1:0] corr_next;
   logic [2:0]        lsb_next;

   always_comb begin
      case (opa[2:0])
         3'd0:       fix = '0;
         3'd1, 3'd7: fix = {2'b00, opb};
         3'd2, 3'd6: fix = {1'b0, opb, 1'b0};
         3'd3, 3'd5: fix = {2'b00, opb} + {1'b0, opb, 1'b0};
         default:    fix = {opb, 2'b00};
      endcase
   end

   // the product drops its low 3 bits here, so a subtraction
   // of a fix with nonzero low bits needs one extra borrow
   assign borrow    = opa[2] & (|fix[2:0]);
   assign corr_next = {1'b0, fix[MANT_W+1:3]} + {{(MANT_W-1){1'b0}}, borrow};

   // the 3 lsbs of the product come straight from a 3x3 table
   assign lsb_next = opa[2:0] * opb[2:0];

   // stage 1: pre-add and correction
   logic [HI_W-1:0]   ah_s1;
   logic [MANT_W-1:0] opb_s1;
   logic [MANT_W-1:0] corr_s1;
   logic              dosub_s1;
   logic [2:0]        lsb_s1;

   always_ff @(posedge clk) begin
      ah_s1    <= opa[MANT_W-1:3] + {{(HI_W-1){1'b0}}, opa[2]};
      opb_s1   <= opb;
      corr_s1  <= corr_next;
      dosub_s1 <= opa[2];
      lsb_s1   <= lsb_next;
   end

   // stage 2: low partial product with the correction folded in,
   // may go negative when subtracting, so it is kept signed
   logic [HI_W+LO_B_W-1:0] prod_lo;
   logic [47:0]            p_low_next;
   logic signed [47:0]     p_low_s2;
   logic [HI_W-1:0]        ah_s2;
   logic [HI_B_W-1:0]      opb_hi_s2;
   logic [2:0]             lsb_s2;

   assign prod_lo = ah_s1 * opb_s1[LO_B_W-1:0];

   always_comb begin
      if (dosub_s1) begin
         p_low_next = {7'b0, prod_lo} - {21'b0, corr_s1};
      end else begin
         p_low_next = {7'b0, prod_lo} + {21'b0, corr_s1};
      end
   end

   always_ff @(posedge clk) begin
      p_low_s2  <= p_low_next;
      ah_s2     <= ah_s1;
      opb_hi_s2 <= opb_s1[MANT_W-1:LO_B_W];
      lsb_s2    <= lsb_s1;
   end

   // stage 3: high partial product plus the low part shifted down by 17
   logic [HI_W+HI_B_W-1:0] prod_hi;
   logic [HI_W+HI_B_W-1:0] p_high_s3;
   logic [LO_B_W-1:0]      p_low_lo_s3;
   logic [2:0]             lsb_s3;

   assign prod_hi = ah_s2 * opb_hi_s2;

   always_ff @(posedge clk) begin
      p_high_s3   <= prod_hi + (HI_W+HI_B_W)'(p_low_s2 >>> LO_B_W);
      p_low_lo_s3 <= p_low_s2[LO_B_W-1:0];
      lsb_s3      <= lsb_s2;
   end

   // stage 4: assemble the product
   always_ff @(posedge clk) begin
      res <= {p_high_s3, p_low_lo_s3, lsb_s3};
   end

endmodule

`default_nettype wire

//--- hw/hrfp_unpack.sv
/*
 Splits two hrfp16 operands. Mantissas leave combinationally for the
 multiplier; sign, exponent sum and zero flag are delayed MULT_LATENCY cycles.
*/

`timescale 1ns/1ps
`default_nettype none

module hrfp_unpack
   import hrfp_pkg::*;
(
   input  wire                clk,
   input  wire                reset,
   input  wire                in_valid,
   input  wire [WORD_W-1:0]   a,
   input  wire [WORD_W-1:0]   b,
   output logic [MANT_W-1:0]  mant_a,
   output logic [MANT_W-1:0]  mant_b,
   hrfp_side_if.producer      side
);

   logic [EXP_W-1:0]        ea;
   logic [EXP_W-1:0]        eb;
   logic                    sign_next;
   logic signed [SUM_W-1:0] exp_sum_next;
   logic                    zero_next;

   assign ea     = a[WORD_W-2:MANT_W];
   assign eb     = b[WORD_W-2:MANT_W];
   assign mant_a = a[MANT_W-1:0];
   assign mant_b = b[MANT_W-1:0];

   assign sign_next    = a[WORD_W-1] ^ b[WORD_W-1];
   assign exp_sum_next = $signed({2'b00, ea}) + $signed({2'b00, eb}) - SUM_W'(EXP_BIAS);
   // exponent field 0 encodes zero whatever the mantissa holds
   assign zero_next    = (ea == '0) || (eb == '0);

   // delay line matching the multiplier stages
   logic                    sign_q    [MULT_LATENCY];
   logic signed [SUM_W-1:0] exp_sum_q [MULT_LATENCY];
   logic                    zero_q    [MULT_LATENCY];
   logic [MULT_LATENCY-1:0] valid_q;

   always_ff @(posedge clk) begin
      sign_q[0]    <= sign_next;
      exp_sum_q[0] <= exp_sum_next;
      zero_q[0]    <= zero_next;
      for (int i = 1; i < MULT_LATENCY; i++) begin
         sign_q[i]    <= sign_q[i-1];
         exp_sum_q[i] <= exp_sum_q[i-1];
         zero_q[i]    <= zero_q[i-1];
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         valid_q <= '0;
      end else begin
         valid_q <= {valid_q[MULT_LATENCY-2:0], in_valid};
      end
   end

   assign side.sign    = sign_q[MULT_LATENCY-1];
   assign side.exp_sum = exp_sum_q[MULT_LATENCY-1];
   assign side.zero    = zero_q[MULT_LATENCY-1];
   assign side.valid   = valid_q[MULT_LATENCY-1];

endmodule

`default_nettype wire

//--- hw/hrfp_normalize.sv
/*
 Hex normalization of the mantissa product with truncation, flush to zero
 on underflow, saturation to the largest finite value on overflow.
 No rounding, infinities or denormals. One register stage.
*/

`timescale 1ns/1ps
`default_nettype none

module hrfp_normalize
   import hrfp_pkg::*;
(
   input  wire                clk,
   input  wire                reset,
   input  wire [PROD_W-1:0]   prod,
   hrfp_side_if.consumer      side,
   output logic               out_valid,
   output logic [WORD_W-1:0]  result
);

   logic                    top_zero;
   logic [MANT_W-1:0]       mant_n;
   logic signed [SUM_W-1:0] exp_n;
   logic                    flush;
   logic                    sat;
   logic [WORD_W-1:0]       result_next;

   // both fractions are at least 1/16, so at most one leading hex digit is zero
   assign top_zero = (prod[PROD_W-1 -: 4] == 4'h0);

   always_comb begin
      if (top_zero) begin
         mant_n = prod[PROD_W-5 -: MANT_W];
         exp_n  = side.exp_sum - SUM_W'(1);
      end else begin
         mant_n = prod[PROD_W-1 -: MANT_W];
         exp_n  = side.exp_sum;
      end
   end

   // a zero operand wins over saturation
   assign flush = side.zero || (exp_n <= SUM_W'(0));
   assign sat   = exp_n > SUM_W'(EXP_MAX);

   always_comb begin
      if (flush) begin
         result_next = {side.sign, {(WORD_W-1){1'b0}}};
      end else if (sat) begin
         result_next = {side.sign, {(WORD_W-1){1'b1}}};
      end else begin
         result_next = {side.sign, exp_n[EXP_W-1:0], mant_n};
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= side.valid;
      end
   end

   always_ff @(posedge clk) begin
      result <= result_next;
   end

endmodule

`default_nettype wire

//--- hw/hrfp_mul.sv
/*
 hrfp16 multiplier, one operand pair per clock, result MUL_LATENCY cycles later.
 No back-pressure: out_valid must be taken whenever it is high.
 Mantissa of a: if bit 26 is set, bits 2..0 must be zero.
*/

`timescale 1ns/1ps
`default_nettype none

module hrfp_mul
   import hrfp_pkg::*;
(
   input  wire                clk,
   input  wire                reset,
   input  wire                in_valid,
   input  wire [WORD_W-1:0]   a,
   input  wire [WORD_W-1:0]   b,
   output logic               out_valid,
   output logic [WORD_W-1:0]  result
);

   logic [MANT_W-1:0] mant_a;
   logic [MANT_W-1:0] mant_b;
   logic [PROD_W-1:0] prod;

   hrfp_side_if side ();

   hrfp_unpack unpack_inst (
      .clk      (clk),
      .reset    (reset),
      .in_valid (in_valid),
      .a        (a),
      .b        (b),
      .mant_a   (mant_a),
      .mant_b   (mant_b),
      .side     (side.producer)
   );

   // product lines up with the delayed side fields
   mult_27x27 mult_inst (
      .clk (clk),
      .opa (mant_a),
      .opb (mant_b),
      .res (prod)
   );

   hrfp_normalize normalize_inst (
      .clk       (clk),
      .reset     (reset),
      .prod      (prod),
      .side      (side.consumer),
      .out_valid (out_valid),
      .result    (result)
   );

endmodule

`default_nettype wire

//--- tests/hrfp_mul_assertions.sv
/*
 Concurrent checks bound into hrfp_mul: the mantissa restriction on a,
 out_valid quiet after reset, and a fixed latency from in_valid to out_valid.
*/

`timescale 1ns/1ps
`default_nettype none

module hrfp_mul_assertions
   import hrfp_pkg::*;
(
   input wire              clk,
   input wire              reset,
   input wire              in_valid,
   input wire [WORD_W-1:0] a,
   input wire              out_valid
);

   // reset seen at the last MUL_LATENCY edges, bit 0 most recent
   logic [MUL_LATENCY-1:0] reset_hist;

   // count of failed assertions
   int failures = 0;

   always_ff @(posedge clk) begin
      reset_hist <= {reset_hist[MUL_LATENCY-2:0], reset};
   end

   restrict_a: assert property (@(posedge clk) disable iff (reset)
      in_valid && a[MANT_W-1] |-> a[2:0] == 3'b000)
      else begin
         failures++;
         $error("mantissa of a has bit 26 and low bits set together");
      end

   reset_quiet: assert property (@(posedge clk) reset |=> !out_valid)
      else begin
         failures++;
         $error("out_valid high right after a reset cycle");
      end

   no_early_valid: assert property (@(posedge clk) disable iff (reset)
      out_valid |-> reset_hist == '0)
      else begin
         failures++;
         $error("out_valid high before the pipeline refilled after reset");
      end

   // in_valid sampled at one edge shows on out_valid MUL_LATENCY samples later
   fixed_latency: assert property (@(posedge clk) disable iff (reset)
      reset_hist == '0 |-> out_valid == $past(in_valid, MUL_LATENCY))
      else begin
         failures++;
         $error("out_valid does not follow in_valid by MUL_LATENCY cycles");
      end

endmodule

bind hrfp_mul hrfp_mul_assertions assertions_inst (
   .clk       (clk),
   .reset     (reset),
   .in_valid  (in_valid),
   .a         (a),
   .out_valid (out_valid)
);

`default_nettype wire

//--- tests/tb_hrfp_mul.sv
/*
 Self-checking testbench for hrfp_mul: seeded random operands, a reference
 model with exact 54-bit products, results compared in issue order.
 Needs a simulator with timing support, Verilator runs it with --timing.
*/

`timescale 1ns/1ps
`default_nettype none

module tb_hrfp_mul
   import hrfp_pkg::*;
();

   localparam int WATCHDOG_CYCLES = 5000;
   localparam int DRAIN_TIMEOUT   = 50;

   // mantissa a values on both sides of the multiplier restriction
   localparam logic [MANT_W-1:0] EDGE_A [6] = '{27'h4000000, 27'h7FFFFF8, 27'h5555550,
                                                 27'h3FFFFFF, 27'h0800007, 27'h1234567};
   localparam logic [MANT_W-1:0] EDGE_B [3] = '{27'h7FFFFFF, 27'h0800000, 27'h4000001};

   logic              clk;
   logic              reset;
   logic              in_valid;
   logic [WORD_W-1:0] a;
   logic [WORD_W-1:0] b;
   logic              out_valid;
   logic [WORD_W-1:0] result;

   integer seed;
   int     cycle = 0;
   int     checks = 0;
   int     value_errors = 0;
   int     timing_errors = 0;
   int     other_errors = 0;

   // expected results and the cycle each one is due, in issue order
   logic [WORD_W-1:0] expect_q[$];
   int                due_q[$];
   logic [WORD_W-1:0] expect_head;
   int                due_head;

   hrfp_mul hrfp_mul_inst (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (in_valid),
      .a         (a),
      .b         (b),
      .out_valid (out_valid),
      .result    (result)
   );

   initial clk = 1'b0;
   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycle <= cycle + 1;
   end

   function automatic int rand_below(input int n);
      return int'({$random(seed)} % n);
   endfunction

   function automatic logic [EXP_W-1:0] rand_exp(input int lo, input int span);
      return EXP_W'(lo + rand_below(span));
   endfunction

   function automatic logic [MANT_W-1:0] rand_mant();
      logic [MANT_W-1:0] m;
      m = MANT_W'($random(seed));
      // keep the fraction normalized, top hex digit nonzero
      if (m[MANT_W-1 -: 4] == 4'h0) begin
         m[MANT_W-1 -: 4] = 4'(1 + rand_below(15));
      end
      return m;
   endfunction

   function automatic logic [MANT_W-1:0] legal_a(input logic [MANT_W-1:0] m);
      logic [MANT_W-1:0] r;
      r = m;
      if (r[MANT_W-1]) begin
         r[2:0] = 3'b000;
      end
      return r;
   endfunction

   // hrfp16 multiply with truncation, flush to zero and saturation
   function automatic logic [WORD_W-1:0] ref_mul(input logic [WORD_W-1:0] x,
                                                 input logic [WORD_W-1:0] y);
      logic              s;
      int                ex;
      int                ey;
      int                e;
      logic [PROD_W-1:0] p;
      logic [MANT_W-1:0] m;
      s  = x[WORD_W-1] ^ y[WORD_W-1];
      ex = int'(x[WORD_W-2 -: EXP_W]);
      ey = int'(y[WORD_W-2 -: EXP_W]);
      if (ex == 0 || ey == 0) begin
         return {s, {(WORD_W-1){1'b0}}};
      end
      p = PROD_W'(x[MANT_W-1:0]) * PROD_W'(y[MANT_W-1:0]);
      e = ex + ey - EXP_BIAS;
      // a zero top hex digit shifts the fraction up by one digit
      if (p[PROD_W-1 -: 4] == 4'h0) begin
         m = p[PROD_W-5 -: MANT_W];
         e = e - 1;
      end else begin
         m = p[PROD_W-1 -: MANT_W];
      end
      if (e <= 0) begin
         return {s, {(WORD_W-1){1'b0}}};
      end
      if (e > EXP_MAX) begin
         return {s, {(WORD_W-1){1'b1}}};
      end
      return {s, EXP_W'(e), m};
   endfunction

   // one operand pair with random signs, held for one clock
   task automatic send(input logic [EXP_W-1:0] ea, input logic [EXP_W-1:0] eb,
                       input logic [MANT_W-1:0] ma, input logic [MANT_W-1:0] mb);
      logic [WORD_W-1:0] x;
      logic [WORD_W-1:0] y;
      x = {rand_below(2) == 1, ea, legal_a(ma)};
      y = {rand_below(2) == 1, eb, mb};
      a        = x;
      b        = y;
      in_valid = 1'b1;
      expect_q.push_back(ref_mul(x, y));
      // driven in this cycle, the result shows MUL_LATENCY cycles later
      due_q.push_back(cycle + MUL_LATENCY);
      @(posedge clk);
      #1;
      in_valid = 1'b0;
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while (expect_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
         @(posedge clk);
         waited++;
      end
      assert (expect_q.size() == 0) else begin
         other_errors++;
         $display("timed out waiting for results, %0d never arrived", expect_q.size());
      end
   endtask

   always @(negedge clk) begin
      if (reset) begin
         assert (out_valid === 1'b0) else begin
            other_errors++;
            $display("ERROR at %0t: out_valid expected 0, actual %b", $time, out_valid);
         end
      end else if (out_valid !== 1'b0) begin
         assert (out_valid === 1'b1 && expect_q.size() != 0) else begin
            other_errors++;
            $display("out_valid was %b at %0t with no operation pending", out_valid, $time);
         end
         if (out_valid === 1'b1 && expect_q.size() != 0) begin
            expect_head = expect_q.pop_front();
            due_head    = due_q.pop_front();
            checks++;
            assert (result === expect_head) else begin
               value_errors++;
               $display("ERROR at %0t: result expected %h, actual %h",
                        $time, expect_head, result);
            end
            assert (cycle == due_head) else begin
               timing_errors++;
               $display("ERROR at %0t: out_valid cycle expected %0d, actual %0d",
                        $time, due_head, cycle);
            end
         end
      end
   end

   initial begin : watchdog
      for (int n = 0; n < WATCHDOG_CYCLES; n++) begin
         @(posedge clk);
      end
      $display("simulation did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("Something failed");
      $finish;
   end

   initial begin : stimulus
      logic [MANT_W-1:0] ma;
      logic [MANT_W-1:0] mb;
      int                assertion_errors;
      seed     = 95906;
      reset    = 1'b1;
      in_valid = 1'b0;
      a        = '0;
      b        = '0;
      repeat (5) @(posedge clk);
      #1;
      reset = 1'b0;

      // random normalized operands with gaps
      for (int i = 0; i < 200; i++) begin
         send(rand_exp(96, 64), rand_exp(96, 64), rand_mant(), rand_mant());
         if (rand_below(4) == 0) begin
            idle(1 + rand_below(3));
         end
      end

      // top digits 1, product lands on the shifted path
      for (int i = 0; i < 40; i++) begin
         ma = rand_mant();
         mb = rand_mant();
         ma[MANT_W-1 -: 4] = 4'h1;
         mb[MANT_W-1 -: 4] = 4'h1;
         send(rand_exp(100, 50), rand_exp(100, 50), ma, mb);
      end

      // zero operands
      for (int i = 0; i < 30; i++) begin
         case (rand_below(3))
            0:       send(8'h00, rand_exp(1, 255), rand_mant(), rand_mant());
            1:       send(rand_exp(1, 255), 8'h00, rand_mant(), rand_mant());
            default: send(8'h00, 8'h00, rand_mant(), rand_mant());
         endcase
      end

      // around the underflow boundary, then around saturation
      for (int i = 0; i < 40; i++) begin
         send(rand_exp(58, 12), rand_exp(58, 12), rand_mant(), rand_mant());
      end
      for (int i = 0; i < 40; i++) begin
         send(rand_exp(186, 14), rand_exp(186, 14), rand_mant(), rand_mant());
      end
      idle(3);

      // back to back, one pair every clock
      for (int i = 0; i < 60; i++) begin
         send(rand_exp(96, 64), rand_exp(96, 64), rand_mant(), rand_mant());
      end
      idle(2);

      // restriction edges, fixed then random
      for (int i = 0; i < 6; i++) begin
         for (int j = 0; j < 3; j++) begin
            send(8'd128, 8'd128, EDGE_A[i], EDGE_B[j]);
         end
      end
      for (int i = 0; i < 20; i++) begin
         ma = rand_mant();
         if (rand_below(2) == 0) begin
            ma[MANT_W-1] = 1'b1;
            ma[2:0]      = 3'b000;
         end else begin
            ma[MANT_W-1] = 1'b0;
            ma[MANT_W-4] = 1'b1;
            ma[2:0]      = 3'b111;
         end
         send(rand_exp(120, 16), rand_exp(120, 16), ma, rand_mant());
      end

      wait_drain();
      // nothing may follow the last result
      idle(2 * MUL_LATENCY);

      assertion_errors = hrfp_mul_inst.assertions_inst.failures;
      $display("checks %0d, value errors %0d, timing errors %0d, other errors %0d, %s %0d",
               checks, value_errors, timing_errors, other_errors,
               "assertion errors", assertion_errors);
      if (value_errors + timing_errors + other_errors + assertion_errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- src.f
hw/hrfp_pkg.sv
hw/hrfp_side_if.sv
hw/mult_27x27.sv
hw/hrfp_unpack.sv
hw/hrfp_normalize.sv
hw/hrfp_mul.sv
tests/hrfp_mul_assertions.sv
tests/tb_hrfp_mul.sv

//--- Makefile
# Verilator build and run of the hrfp_mul testbench

VERILATOR ?= verilator
FILELIST  ?= src.f
TOP       ?= tb_hrfp_mul
LINT_TOP  ?= hrfp_mul
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Everything OK

RTL_FILES := $(filter hw/%,$(shell cat $(FILELIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(LINT_TOP) $(RTL_FILES)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
